// ==== sim.f ====
+incdir+src
src/mem_pkg.sv
src/mem_access_fsm.sv
src/wait_timer.sv
src/store_aligner.sv
src/load_extractor.sv
src/data_ram.sv
src/memory_unit.sv
verification/tb_clock.sv
verification/memory_unit_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the memory unit testbench with verilator and runs it.

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --assert --timescale 1ns/1ps -f sim.f \
    --top-module memory_unit_tb -Mdir "$build_dir" -o memory_unit_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/memory_unit_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"

if grep -q "Checks failed" "$log_file"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished without failures"
exit 0

// ==== verification/memory_unit_tb.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module memory_unit_tb;

    localparam int NUM_WORDS     = `MEM_WORDS;
    localparam int NUM_RANDOM    = 400;
    localparam int NUM_UNALIGNED = 8;
    localparam int NUM_NOISY     = 8;
    localparam int ACCESS_CYCLES = `MEM_WAIT + 4;  // request to request spacing.
    // fill, readback, final readback, random and extra accesses, then the pc sweep.
    localparam int TIMEOUT_CYCLES =
        (3 * NUM_WORDS + NUM_RANDOM + NUM_UNALIGNED + NUM_NOISY) * ACCESS_CYCLES
        + 2 * NUM_WORDS + 100;

    logic           clk;
    logic           reset;
    mem_pkg::addr_t pc;
    mem_pkg::addr_t mem_addr;
    mem_pkg::xlen_t mem_wdata;
    mem_pkg::wdt_t  wdt_op;
    logic           mem_ren;
    logic           mem_wen;
    mem_pkg::inst_t inst;
    mem_pkg::xlen_t mem_rdata;
    logic           busy;
    logic           done;

    logic [7:0]     shadow [1 << `MEM_ADDR_W];  // byte image of the data memory.
    logic [31:0]    rng_state = 32'h642f3205;
    int             cycle     = 0;
    int             completed = 0;
    logic           sweep_on;
    logic           done_prev = 1'b0;
    logic           seen_load = 1'b0;
    mem_pkg::xlen_t last_load = '0;

    // one entry per accepted request.
    logic           exp_load_q [$];
    mem_pkg::xlen_t exp_val_q [$];
    int             accept_q [$];

    tb_clock u_clock (
        .clk (clk)
    );

    memory_unit u_memory_unit (
        .clk       (clk),
        .reset     (reset),
        .pc        (pc),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .wdt_op    (wdt_op),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .inst      (inst),
        .mem_rdata (mem_rdata),
        .busy      (busy),
        .done      (done)
    );

    // **********************************************************************
    // reporting and reference model
    // **********************************************************************
    task automatic abort_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        $display("error %s expected %h got %h", name, expected, actual);
        abort_run();
    endtask

    task automatic flag_problem(input string what);
        $display("%s", what);
        abort_run();
    endtask

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // aligned slice below addr, zero-extended.
    function automatic mem_pkg::xlen_t load_ref(input mem_pkg::addr_t addr,
                                                input mem_pkg::wdt_t wdt);
        int             nbytes;
        int             base;
        int             b;
        mem_pkg::xlen_t value;
        nbytes = 1 << int'(wdt);
        base   = int'(addr) & ~(nbytes - 1);
        value  = '0;
        for (b = nbytes - 1; b >= 0; b--) begin
            value = {value[55:0], shadow[base + b]};
        end
        return value;
    endfunction

    function automatic void shadow_store(input mem_pkg::addr_t addr, input mem_pkg::xlen_t data,
                                         input mem_pkg::wdt_t wdt);
        int nbytes;
        int base;
        int b;
        nbytes = 1 << int'(wdt);
        base   = int'(addr) & ~(nbytes - 1);
        for (b = 0; b < nbytes; b++) begin
            shadow[base + b] = data[b*8 +: 8];
        end
    endfunction

    // little endian, pc bit 2 picks the upper half.
    function automatic mem_pkg::inst_t inst_ref(input mem_pkg::addr_t pc_val);
        int base;
        base = int'(pc_val) & ~3;
        return {shadow[base + 3], shadow[base + 2], shadow[base + 1], shadow[base]};
    endfunction

    // one request, optionally with ignored strobes while busy.
    task automatic access(input logic is_load, input mem_pkg::addr_t addr,
                          input mem_pkg::xlen_t data, input mem_pkg::wdt_t wdt,
                          input logic noisy);
        mem_pkg::xlen_t expected;
        logic [31:0]    r;
        expected = '0;
        if (is_load) begin
            expected = load_ref(addr, wdt);
        end else begin
            shadow_store(addr, data, wdt);
        end
        @(posedge clk);
        mem_addr  <= addr;
        mem_wdata <= data;
        wdt_op    <= wdt;
        mem_ren   <= is_load;
        mem_wen   <= ~is_load;
        @(posedge clk);  // accept edge.
        mem_ren <= 1'b0;
        mem_wen <= 1'b0;
        exp_load_q.push_back(is_load);
        exp_val_q.push_back(expected);
        accept_q.push_back(cycle + 1);
        if (noisy) begin
            r = lcg_next();
            @(posedge clk);
            mem_addr  <= r[31:23];
            mem_wdata <= {r, ~r};
            wdt_op    <= mem_pkg::WDT_64;
            mem_wen   <= 1'b1;
            @(posedge clk);
            mem_wen <= 1'b0;
            mem_ren <= 1'b1;
            @(posedge clk);
            mem_ren <= 1'b0;  // low again before the done edge.
        end
        @(negedge clk);
        while (!done) begin
            @(negedge clk);
        end
    endtask

    // **********************************************************************
    // comparison and timeout
    // **********************************************************************
    always @(negedge clk) begin : compare_results
        logic           was_load;
        mem_pkg::xlen_t expected;
        int             accepted_at;
        if (done_prev) begin
            assert (!busy && !done)
                else flag_problem("busy or done still high in the cycle after done");
        end
        done_prev = 1'b0;
        if (!reset && done) begin
            assert (exp_val_q.size() != 0)
                else flag_problem("done pulsed with no request outstanding");
            was_load    = exp_load_q.pop_front();
            expected    = exp_val_q.pop_front();
            accepted_at = accept_q.pop_front();
            assert ((cycle - accepted_at) == (`MEM_WAIT + 2))
                else flag_problem($sformatf("done came %0d edges after the accept edge",
                                            cycle - accepted_at));
            assert (busy) else flag_mismatch("busy", 64'd1, {63'd0, busy});
            if (was_load) begin
                assert (mem_rdata == expected)
                    else flag_mismatch("mem_rdata", expected, mem_rdata);
                last_load = expected;
                seen_load = 1'b1;
            end else if (seen_load) begin
                assert (mem_rdata == last_load)  // held across stores.
                    else flag_mismatch("mem_rdata", last_load, mem_rdata);
            end
            completed++;
            done_prev = 1'b1;
        end
        if (sweep_on) begin
            assert (inst == inst_ref(pc))
                else flag_mismatch("inst", {32'd0, inst_ref(pc)}, {32'd0, inst});
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        assert (cycle < TIMEOUT_CYCLES)
            else flag_problem($sformatf("timeout after %0d cycles", cycle));
    end

    // **********************************************************************
    // stimulus
    // **********************************************************************
    initial begin : stimulus
        logic [31:0]    r;
        logic [31:0]    s;
        mem_pkg::xlen_t data;
        int             i;
        reset     <= 1'b1;
        pc        <= '0;
        mem_addr  <= '0;
        mem_wdata <= '0;
        wdt_op    <= mem_pkg::WDT_64;
        mem_ren   <= 1'b0;
        mem_wen   <= 1'b0;
        sweep_on  <= 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;

        repeat (4) begin
            @(negedge clk);
            assert (!busy && !done)
                else flag_problem("busy or done high before the first request");
        end

        for (i = 0; i < NUM_WORDS; i++) begin
            data = {lcg_next(), lcg_next()};
            access(1'b0, mem_pkg::addr_t'(i * 8), data, mem_pkg::WDT_64, 1'b0);
        end
        for (i = 0; i < NUM_WORDS; i++) begin
            access(1'b1, mem_pkg::addr_t'(i * 8), '0, mem_pkg::WDT_64, 1'b0);
        end

        // mixed widths, addresses mostly unaligned.
        for (i = 0; i < NUM_RANDOM; i++) begin
            r    = lcg_next();
            s    = lcg_next();
            data = {lcg_next(), lcg_next()};
            access(s[31], r[31:23], data, mem_pkg::wdt_t'(s[30:29]), 1'b0);
        end

        for (i = 0; i < NUM_UNALIGNED; i++) begin
            r = lcg_next();
            access(1'b1, r[31:23] | 9'h001, '0, mem_pkg::wdt_t'(2'(1 + i % 3)), 1'b0);
        end

        for (i = 0; i < NUM_NOISY; i++) begin
            r    = lcg_next();
            s    = lcg_next();
            data = {lcg_next(), lcg_next()};
            access(i[0], r[31:23], data, mem_pkg::wdt_t'(s[30:29]), 1'b1);
        end

        // catches any lane written outside its mask.
        for (i = 0; i < NUM_WORDS; i++) begin
            access(1'b1, mem_pkg::addr_t'(i * 8), '0, mem_pkg::WDT_64, 1'b0);
        end

        for (i = 0; i < 2 * NUM_WORDS; i++) begin
            r = lcg_next();
            @(posedge clk);
            pc       <= mem_pkg::addr_t'(i * 4) | mem_pkg::addr_t'(r[31:30]);
            sweep_on <= 1'b1;
        end
        @(posedge clk);
        sweep_on <= 1'b0;
        @(negedge clk);
        assert (exp_val_q.size() == 0)
            else flag_problem("requests left without a done pulse");

        $display("%0d accesses completed", completed);
        $display("All checks passed");
        $finish;
    end

endmodule

// ==== verification/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk
);

    localparam time HALF_PERIOD = 10ns;  // 20 ns period.

    initial begin
        clk = 1'b0;
        forever begin
            #HALF_PERIOD clk = ~clk;
        end
    end

endmodule

// ==== src/memory_unit.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module memory_unit (
    input  logic           clk,
    input  logic           reset,
    input  mem_pkg::addr_t pc,
    input  mem_pkg::addr_t mem_addr,
    input  mem_pkg::xlen_t mem_wdata,
    input  mem_pkg::wdt_t  wdt_op,
    input  logic           mem_ren,
    input  logic           mem_wen,
    output mem_pkg::inst_t inst,
    output mem_pkg::xlen_t mem_rdata,
    output logic           busy,
    output logic           done
);

    logic               timer_start;
    logic               expired;
    logic               ram_ren;
    logic               ram_wen;
    logic               rdata_capture;
    mem_pkg::addr_t     req_addr;
    mem_pkg::xlen_t     req_wdata;
    mem_pkg::wdt_t      req_wdt;
    mem_pkg::xlen_t     lane_wdata;
    mem_pkg::wmask_t    wmask;
    mem_pkg::xlen_t     rdata_word;
    mem_pkg::word_idx_t word_index;

    assign word_index = req_addr[`MEM_ADDR_W-1:3];  // doubleword part of the address.

    mem_access_fsm u_fsm (
        .clk           (clk),
        .reset         (reset),
        .mem_ren       (mem_ren),
        .mem_wen       (mem_wen),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .wdt_op        (wdt_op),
        .expired       (expired),
        .timer_start   (timer_start),
        .ram_ren       (ram_ren),
        .ram_wen       (ram_wen),
        .rdata_capture (rdata_capture),
        .busy          (busy),
        .done          (done),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_wdt       (req_wdt)
    );

    wait_timer u_timer (
        .clk         (clk),
        .reset       (reset),
        .timer_start (timer_start),
        .expired     (expired)
    );

    store_aligner u_aligner (
        .req_addr   (req_addr),
        .req_wdata  (req_wdata),
        .req_wdt    (req_wdt),
        .lane_wdata (lane_wdata),
        .wmask      (wmask)
    );

    load_extractor u_extractor (
        .clk           (clk),
        .rdata_capture (rdata_capture),
        .req_addr      (req_addr),
        .req_wdt       (req_wdt),
        .rdata_word    (rdata_word),
        .mem_rdata     (mem_rdata)
    );

    data_ram u_ram (
        .clk        (clk),
        .ram_ren    (ram_ren),
        .ram_wen    (ram_wen),
        .word_index (word_index),
        .lane_wdata (lane_wdata),
        .wmask      (wmask),
        .pc         (pc),
        .rdata_word (rdata_word),
        .inst       (inst)
    );

endmodule

// ==== src/data_ram.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module data_ram (
    input  logic               clk,
    input  logic               ram_ren,
    input  logic               ram_wen,
    input  mem_pkg::word_idx_t word_index,
    input  mem_pkg::xlen_t     lane_wdata,
    input  mem_pkg::wmask_t    wmask,
    input  mem_pkg::addr_t     pc,
    output mem_pkg::xlen_t     rdata_word,
    output mem_pkg::inst_t     inst
);

    mem_pkg::xlen_t mem [`MEM_WORDS];
    mem_pkg::xlen_t pc_word;

    // **********************************************************************
    // data port
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (ram_wen) begin
            for (int i = 0; i < 8; i++) begin
                if (wmask[i]) begin
                    mem[word_index][i*8 +: 8] <= lane_wdata[i*8 +: 8];
                end
            end
        end
        if (ram_ren) begin
            rdata_word <= mem[word_index];  // registered read.
        end
    end

    // **********************************************************************
    // instruction port
    // **********************************************************************
    assign pc_word = mem[pc[`MEM_ADDR_W-1:3]];

    // pc bit 2 picks the upper half.
    assign inst = pc[2] ? pc_word[63:32] : pc_word[31:0];

endmodule

// ==== src/load_extractor.sv ====
`timescale 1ns/1ps

module load_extractor (
    input  logic           clk,
    input  logic           rdata_capture,
    input  mem_pkg::addr_t req_addr,
    input  mem_pkg::wdt_t  req_wdt,
    input  mem_pkg::xlen_t rdata_word,
    output mem_pkg::xlen_t mem_rdata
);

    logic [2:0]     lane_off;
    mem_pkg::xlen_t shifted;
    mem_pkg::xlen_t slice_zext;
    mem_pkg::xlen_t held;

    // **********************************************************************
    // slice select
    // **********************************************************************
    always_comb begin
        case (req_wdt)
            mem_pkg::WDT_8:  lane_off = req_addr[2:0];
            mem_pkg::WDT_16: lane_off = {req_addr[2:1], 1'b0};
            mem_pkg::WDT_32: lane_off = {req_addr[2], 2'b00};
            default:         lane_off = 3'b000;
        endcase
    end

    // addressed lane moved down to bit 0.
    assign shifted = rdata_word >> {lane_off, 3'b000};

    always_comb begin
        case (req_wdt)
            mem_pkg::WDT_8:  slice_zext = {56'd0, shifted[7:0]};
            mem_pkg::WDT_16: slice_zext = {48'd0, shifted[15:0]};
            mem_pkg::WDT_32: slice_zext = {32'd0, shifted[31:0]};
            default:         slice_zext = shifted;
        endcase
    end

    // **********************************************************************
    // result hold
    // **********************************************************************
    always_ff @(posedge clk) begin
        if (rdata_capture) begin
            held <= slice_zext;
        end
    end

    // fresh value during the capture cycle, then the held copy.
    assign mem_rdata = rdata_capture ? slice_zext : held;

endmodule

// ==== src/store_aligner.sv ====
`timescale 1ns/1ps

module store_aligner (
    input  mem_pkg::addr_t  req_addr,
    input  mem_pkg::xlen_t  req_wdata,
    input  mem_pkg::wdt_t   req_wdt,
    output mem_pkg::xlen_t  lane_wdata,
    output mem_pkg::wmask_t wmask
);

    logic [2:0]      lane_off;
    mem_pkg::xlen_t  data_zext;
    mem_pkg::wmask_t base_mask;

    // low address bits below the width are dropped.
    always_comb begin
        lane_off  = 3'b000;
        base_mask = 8'hFF;
        data_zext = req_wdata;
        case (req_wdt)
            mem_pkg::WDT_8: begin
                lane_off  = req_addr[2:0];
                base_mask = 8'h01;
                data_zext = {56'd0, req_wdata[7:0]};
            end
            mem_pkg::WDT_16: begin
                lane_off  = {req_addr[2:1], 1'b0};
                base_mask = 8'h03;
                data_zext = {48'd0, req_wdata[15:0]};
            end
            mem_pkg::WDT_32: begin
                lane_off  = {req_addr[2], 2'b00};
                base_mask = 8'h0F;
                data_zext = {32'd0, req_wdata[31:0]};
            end
            default: ;  // full doubleword.
        endcase
    end

    assign lane_wdata = data_zext << {lane_off, 3'b000};
    assign wmask      = base_mask << lane_off;

endmodule

// ==== src/wait_timer.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module wait_timer (
    input  logic clk,
    input  logic reset,
    input  logic timer_start,
    output logic expired
);

    localparam int CNT_W = $clog2(`MEM_WAIT + 2);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (timer_start) begin
            count <= CNT_W'(`MEM_WAIT);
        end else if (count != '0) begin
            count <= count - 1'b1;  // parks at zero.
        end
    end

    // level, stays up until the next start.
    assign expired = (count == '0);

endmodule

// ==== src/mem_access_fsm.sv ====
`timescale 1ns/1ps
`include "mem_macros.svh"

module mem_access_fsm (
    input  logic             clk,
    input  logic             reset,
    input  logic             mem_ren,
    input  logic             mem_wen,
    input  mem_pkg::addr_t   mem_addr,
    input  mem_pkg::xlen_t   mem_wdata,
    input  mem_pkg::wdt_t    wdt_op,
    input  logic             expired,
    output logic             timer_start,
    output logic             ram_ren,
    output logic             ram_wen,
    output logic             rdata_capture,
    output logic             busy,
    output logic             done,
    output mem_pkg::addr_t   req_addr,
    output mem_pkg::xlen_t   req_wdata,
    output mem_pkg::wdt_t    req_wdt
);

    mem_pkg::acc_state_t state;
    mem_pkg::acc_state_t state_next;
    logic                req_store;
    logic                accept;

    // a new request may land in idle or on the done cycle.
    assign accept = ((state == mem_pkg::ST_IDLE) || (state == mem_pkg::ST_DONE)) &&
                    (mem_ren ^ mem_wen);

    assign timer_start = accept;
    assign ram_ren     = (state == mem_pkg::ST_ACCESS) && !req_store;
    assign ram_wen     = (state == mem_pkg::ST_ACCESS) && req_store;
    assign done        = (state == mem_pkg::ST_DONE);

    always_comb begin
        state_next = state;
        case (state)
            mem_pkg::ST_IDLE:   if (accept) state_next = mem_pkg::ST_WAIT;
            mem_pkg::ST_WAIT:   if (expired) state_next = mem_pkg::ST_ACCESS;
            mem_pkg::ST_ACCESS: state_next = mem_pkg::ST_DONE;
            mem_pkg::ST_DONE:   state_next = accept ? mem_pkg::ST_WAIT : mem_pkg::ST_IDLE;
            default:            state_next = mem_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= mem_pkg::ST_IDLE;
            busy          <= 1'b0;
            rdata_capture <= 1'b0;
        end else begin
            state         <= state_next;
            rdata_capture <= ram_ren;  // ram word is ready one edge later.
            if (accept) begin
                busy <= 1'b1;
            end else if (state == mem_pkg::ST_DONE) begin
                busy <= 1'b0;  // falls together with done.
            end
        end
    end

    // request payload, held until the next accept.
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr  <= mem_addr;
            req_wdata <= mem_wdata;
            req_wdt   <= wdt_op;
            req_store <= mem_wen;
        end
    end

    // **********************************************************************
    // protocol checks
    // **********************************************************************

    // done is sampled high MEM_WAIT+3 edges on, i.e. it rises MEM_WAIT+2 edges after accept.
    a_done_latency: assert property (@(posedge clk) disable iff (reset)
        accept |-> ##(`MEM_WAIT + 3) done);

    a_no_strobe_busy: assert property (@(posedge clk) disable iff (reset)
        ($rose(mem_ren) || $rose(mem_wen)) |-> (!busy || done))
        else $warning("request strobe raised while busy, ignored");

    a_single_strobe: assert property (@(posedge clk) disable iff (reset)
        !(mem_ren && mem_wen))
        else $error("mem_ren and mem_wen high together");

endmodule

// ==== src/mem_pkg.sv ====
`include "mem_macros.svh"

package mem_pkg;

    // **********************************************************************
    // data and address vectors
    // **********************************************************************
    typedef logic [63:0]                   xlen_t;      // one doubleword.
    typedef logic [`MEM_ADDR_W-1:0]        addr_t;      // byte address.
    typedef logic [$clog2(`MEM_WORDS)-1:0] word_idx_t;  // doubleword index.
    typedef logic [31:0]                   inst_t;
    typedef logic [7:0]                    wmask_t;     // one bit per byte lane.

    // access width, same order as the core's wdt_op field.
    typedef enum logic [1:0] {
        WDT_8  = 2'b00,
        WDT_16 = 2'b01,
        WDT_32 = 2'b10,
        WDT_64 = 2'b11
    } wdt_t;

    typedef enum logic [1:0] {
        ST_IDLE   = 2'b00,
        ST_WAIT   = 2'b01,
        ST_ACCESS = 2'b10,
        ST_DONE   = 2'b11
    } acc_state_t;

endpackage

// ==== src/mem_macros.svh ====
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// **********************************************************************
// memory unit sizing
// **********************************************************************

// byte address width, 512 bytes of local data memory.
`define MEM_ADDR_W 9

// doublewords held by the data memory.
`define MEM_WORDS 64

// **********************************************************************
// latency
// **********************************************************************

// wait states spent before the ram is touched.
`define MEM_WAIT 2

`endif
